/* common/jsp_consts.svh */
/* Sizes for the JTAG serial port
   Count fields are one nibble wide, so the FIFO depth must stay below 16
   The FIFO depth must be a power of two */
`ifndef JSP_CONSTS_SVH
`define JSP_CONSTS_SVH

// Width of one byte moved in either direction
`define JSP_WORD_W 8

// Width of every count field in the counts byte
`define JSP_NIB_W 4

// Entries in each FIFO
`define JSP_FIFO_DEPTH 8

`define JSP_BIT_MAX 7        // Bit count of the last bit of a byte

`define JSP_MULTI_DEFAULT 1  // Wait for a start bit on TDI by default

`endif

/* common/jsp_pkg.sv */
/* Types for the JTAG serial port
   Field order of jsp_counts_t is the bit layout of the counts byte on TDO */
`include "jsp_consts.svh"

package jsp_pkg;

  typedef logic [`JSP_WORD_W-1:0] jsp_byte_t;  // One transferred byte
  typedef logic [`JSP_NIB_W-1:0]  jsp_count_t; // One nibble count

  // TAP strobes seen by this module
  typedef struct packed {
    logic select;   // Module selected in the chain
    logic capture;  // Capture-DR pulse
    logic shift;    // Shift-DR, one bit per cycle
    logic update;   // Update-DR pulse, ends the scan
  } jsp_tap_t;

  // Counts byte, bytes_avail in the high nibble
  typedef struct packed {
    jsp_count_t bytes_avail;  // Bytes waiting toward JTAG
    jsp_count_t space_free;   // Free entries toward the CPU
  } jsp_counts_t;

  // Input side, JTAG toward CPU
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_WAIT,    // Waiting for the start bit
    WR_COUNTS,  // Receiving the user count byte
    WR_XFER     // Receiving data bytes
  } wr_state_e;

  // Output side, CPU toward JTAG
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_COUNTS,  // Shifting out the counts byte
    RD_RDACK,   // First bit of a byte, pops the loaded byte
    RD_XFER     // Remaining bits of a data byte
  } rd_state_e;

endpackage

/* design/jsp_fifo.sv */
/* Byte FIFO with occupancy count
   Push when full is dropped unless a pop happens in the same cycle
   Pop when empty is dropped, head data is only valid while count_o is nonzero */
`timescale 1ns/1ps
`include "jsp_consts.svh"

module jsp_fifo (
  input  logic                tck_i,
  input  logic                rst_i,
  input  logic                push_i,
  input  jsp_pkg::jsp_byte_t  data_i,
  input  logic                pop_i,
  output jsp_pkg::jsp_byte_t  data_o,
  output jsp_pkg::jsp_count_t count_o
);

  localparam int PTR_W = $clog2(`JSP_FIFO_DEPTH);
  localparam jsp_pkg::jsp_count_t DEPTH = `JSP_FIFO_DEPTH;

  jsp_pkg::jsp_byte_t  mem [`JSP_FIFO_DEPTH];  // Storage, no reset
  logic [PTR_W-1:0]    wr_ptr_q;               // Next free slot
  logic [PTR_W-1:0]    rd_ptr_q;               // Oldest entry
  jsp_pkg::jsp_count_t count_q;

  logic full;
  logic empty;
  logic do_push;
  logic do_pop;

  assign full    = (count_q == DEPTH);
  assign empty   = (count_q == '0);
  assign do_pop  = pop_i && !empty;
  assign do_push = push_i && (!full || do_pop);  // Full slot frees up on a pop

  // Storage write
  always_ff @(posedge tck_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
      // Push with pop keeps the count
    end
  end

  assign data_o  = mem[rd_ptr_q];  // Head of queue
  assign count_o = count_q;

endmodule

/* design/jsp_wr_ctrl.sv */
/* Input control machine, bytes from TDI toward the CPU FIFO
   Bytes arrive LSB first, the first byte carries the user count in its high nibble
   push_o is a single-cycle combinational strobe during the last bit of a byte */
`timescale 1ns/1ps
`include "jsp_consts.svh"

module jsp_wr_ctrl #(
  parameter int SUPPORT_MULTI = `JSP_MULTI_DEFAULT  // Nonzero waits for a start bit
) (
  input  logic                tck_i,
  input  logic                rst_i,
  input  jsp_pkg::jsp_tap_t   tap_i,
  input  logic                tdi_i,
  input  jsp_pkg::jsp_count_t space_free_i,
  output logic                push_o,
  output jsp_pkg::jsp_byte_t  data_o
);

  localparam logic [`JSP_NIB_W-1:0] BIT_MAX = `JSP_BIT_MAX;

  jsp_pkg::wr_state_e    state_q, state_d;
  logic [`JSP_NIB_W-1:0] bit_cnt_q;    // Bits received of the current byte
  jsp_pkg::jsp_byte_t    shift_q;      // Shift-in register, no reset
  jsp_pkg::jsp_count_t   space_cnt_q;  // Free entries left in the rx FIFO
  jsp_pkg::jsp_count_t   user_cnt_q;   // Bytes the host still intends to send

  jsp_pkg::jsp_byte_t byte_in;  // Complete byte once the last bit is on TDI
  logic bit_max;
  logic bit_clr, bit_en;
  logic shift_en;
  logic space_ld, user_ld;

  assign byte_in = {tdi_i, shift_q[`JSP_WORD_W-1:1]};
  assign bit_max = (bit_cnt_q == BIT_MAX);

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      bit_cnt_q <= '0;
    end else if (bit_clr) begin
      bit_cnt_q <= '0;
    end else if (bit_en) begin
      bit_cnt_q <= bit_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge tck_i) begin
    if (shift_en) shift_q <= byte_in;  // LSB first, new bit enters at the top
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      space_cnt_q <= '0;
      user_cnt_q  <= '0;
    end else begin
      if (space_ld) begin
        space_cnt_q <= space_free_i;  // Snapshot at capture
      end else if (push_o) begin
        space_cnt_q <= space_cnt_q - 1'b1;
      end
      if (user_ld) begin
        user_cnt_q <= byte_in[`JSP_WORD_W-1 -: `JSP_NIB_W];  // High nibble is K
      end else if (push_o) begin
        user_cnt_q <= user_cnt_q - 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) state_q <= jsp_pkg::WR_IDLE;
    else       state_q <= state_d;
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      jsp_pkg::WR_IDLE: begin
        if (tap_i.select && tap_i.capture) begin
          state_d = (SUPPORT_MULTI != 0) ? jsp_pkg::WR_WAIT : jsp_pkg::WR_COUNTS;
        end
      end
      jsp_pkg::WR_WAIT: begin
        if (tap_i.update) state_d = jsp_pkg::WR_IDLE;
        else if (tap_i.select && tap_i.shift && tdi_i) state_d = jsp_pkg::WR_COUNTS;  // Start bit
      end
      jsp_pkg::WR_COUNTS: begin
        if (tap_i.update) state_d = jsp_pkg::WR_IDLE;
        else if (tap_i.shift && bit_max) state_d = jsp_pkg::WR_XFER;
      end
      jsp_pkg::WR_XFER: begin
        if (tap_i.update) state_d = jsp_pkg::WR_IDLE;  // Stays until the scan ends
      end
      default: state_d = jsp_pkg::WR_IDLE;
    endcase
  end

  // Control strobes, pauses leave everything idle
  always_comb begin
    bit_clr  = 1'b0;
    bit_en   = 1'b0;
    shift_en = 1'b0;
    space_ld = 1'b0;
    user_ld  = 1'b0;
    push_o   = 1'b0;
    unique case (state_q)
      jsp_pkg::WR_IDLE: begin
        if (state_d != jsp_pkg::WR_IDLE) begin
          bit_clr  = 1'b1;
          space_ld = 1'b1;
        end
      end
      jsp_pkg::WR_COUNTS: begin
        if (tap_i.shift) begin
          bit_en   = 1'b1;
          shift_en = 1'b1;
          bit_clr  = bit_max;
          user_ld  = bit_max;  // Count byte complete
        end
      end
      jsp_pkg::WR_XFER: begin
        if (tap_i.shift) begin
          bit_en   = 1'b1;
          shift_en = 1'b1;
          bit_clr  = bit_max;
          push_o   = bit_max && (space_cnt_q != '0) && (user_cnt_q != '0);
        end
      end
      default: ;  // WR_WAIT only watches TDI
    endcase
  end

  assign data_o = byte_in;

endmodule

/* design/jsp_rd_ctrl.sv */
/* Output control machine, counts byte then queued bytes out on TDO
   A loaded byte is popped from the tx FIFO on the first bit after its load
   Bytes past the count captured at scan start are shifted as zeros */
`timescale 1ns/1ps
`include "jsp_consts.svh"

module jsp_rd_ctrl (
  input  logic                 tck_i,
  input  logic                 rst_i,
  input  jsp_pkg::jsp_tap_t    tap_i,
  input  jsp_pkg::jsp_counts_t counts_i,
  input  jsp_pkg::jsp_byte_t   head_i,
  output logic                 pop_o,
  output logic                 tdo_o
);

  localparam logic [`JSP_NIB_W-1:0] BIT_MAX = `JSP_BIT_MAX;

  jsp_pkg::rd_state_e    state_q, state_d;
  logic [`JSP_NIB_W-1:0] bit_cnt_q;   // Bits sent of the current byte
  jsp_pkg::jsp_count_t   word_cnt_q;  // Bytes still owed to the host
  jsp_pkg::jsp_byte_t    sr_q;        // Parallel-load output shift register

  logic bit_max;
  logic word_zero;
  logic bit_clr, bit_en;
  logic word_ld;
  logic sr_clr;         // Scan ended, drop leftover bits
  logic sr_ld_counts;   // Load counts byte at capture
  logic sr_ld_head;     // Load next FIFO byte
  logic sr_shift;

  assign bit_max   = (bit_cnt_q == BIT_MAX);
  assign word_zero = (word_cnt_q == '0);

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      bit_cnt_q <= '0;
    end else if (bit_clr) begin
      bit_cnt_q <= '0;
    end else if (bit_en) begin
      bit_cnt_q <= bit_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      word_cnt_q <= '0;
    end else if (word_ld) begin
      word_cnt_q <= counts_i.bytes_avail;  // Snapshot at capture
    end else if (pop_o) begin
      word_cnt_q <= word_cnt_q - 1'b1;     // One byte handed over
    end
  end

  // Reset keeps TDO low out of reset
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      sr_q <= '0;
    end else if (sr_clr) begin
      sr_q <= '0;
    end else if (sr_ld_counts) begin
      sr_q <= counts_i;
    end else if (sr_ld_head) begin
      sr_q <= head_i;
    end else if (sr_shift) begin
      sr_q <= {1'b0, sr_q[`JSP_WORD_W-1:1]};  // Zeros fill from the top
    end
  end

  assign tdo_o = sr_q[0];  // LSB first

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) state_q <= jsp_pkg::RD_IDLE;
    else       state_q <= state_d;
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      jsp_pkg::RD_IDLE: begin
        if (tap_i.select && tap_i.capture) state_d = jsp_pkg::RD_COUNTS;
      end
      jsp_pkg::RD_COUNTS,
      jsp_pkg::RD_XFER: begin
        if (tap_i.update) state_d = jsp_pkg::RD_IDLE;
        else if (tap_i.shift && bit_max) state_d = jsp_pkg::RD_RDACK;
      end
      jsp_pkg::RD_RDACK: begin
        if (tap_i.update) state_d = jsp_pkg::RD_IDLE;
        else if (tap_i.shift) state_d = jsp_pkg::RD_XFER;  // Only one bit long
      end
      default: state_d = jsp_pkg::RD_IDLE;
    endcase
  end

  // Control strobes
  always_comb begin
    bit_clr      = 1'b0;
    bit_en       = 1'b0;
    word_ld      = 1'b0;
    sr_clr       = 1'b0;
    sr_ld_counts = 1'b0;
    sr_ld_head   = 1'b0;
    sr_shift     = 1'b0;
    pop_o        = 1'b0;
    unique case (state_q)
      jsp_pkg::RD_IDLE: begin
        if (state_d != jsp_pkg::RD_IDLE) begin
          bit_clr      = 1'b1;
          word_ld      = 1'b1;
          sr_ld_counts = 1'b1;
        end
      end
      jsp_pkg::RD_COUNTS,
      jsp_pkg::RD_XFER: begin
        sr_clr = tap_i.update;
        if (tap_i.shift) begin
          bit_en = 1'b1;
          if (bit_max) begin
            bit_clr    = 1'b1;
            sr_ld_head = !word_zero;  // Latch now, pop in RD_RDACK
            sr_shift   = word_zero;
          end else begin
            sr_shift = 1'b1;
          end
        end
      end
      jsp_pkg::RD_RDACK: begin
        sr_clr = tap_i.update;
        if (tap_i.shift) begin
          bit_en   = 1'b1;
          sr_shift = 1'b1;
          pop_o    = !word_zero;
        end
      end
      default: ;
    endcase
  end

endmodule

/* design/jsp_top.sv */
/* JTAG serial port top, debug host on the TAP side and a byte port on the CPU side
   Both sides run on tck_i, there is no back-pressure toward the CPU
   CPU writes to a full tx FIFO and reads of an empty rx FIFO are dropped */
`timescale 1ns/1ps
`include "jsp_consts.svh"

module jsp_top #(
  parameter int SUPPORT_MULTI = `JSP_MULTI_DEFAULT  // Start-bit wait for multi-device chains
) (
  input  logic               tck_i,
  input  logic               rst_i,
  input  jsp_pkg::jsp_tap_t  tap_i,
  input  logic               tdi_i,
  output logic               tdo_o,
  input  logic               cpu_wr_i,        // Push one byte toward JTAG
  input  jsp_pkg::jsp_byte_t cpu_wdata_i,
  input  logic               cpu_rd_i,        // Pop one byte received from JTAG
  output jsp_pkg::jsp_byte_t cpu_rdata_o,     // Head of the rx FIFO
  output logic               cpu_rx_valid_o   // rx FIFO not empty
);

  localparam jsp_pkg::jsp_count_t DEPTH = `JSP_FIFO_DEPTH;

  logic                 rx_push;   // From the input machine
  jsp_pkg::jsp_byte_t   rx_data;
  jsp_pkg::jsp_count_t  rx_count;
  logic                 tx_pop;    // From the output machine
  jsp_pkg::jsp_byte_t   tx_head;
  jsp_pkg::jsp_count_t  tx_count;
  jsp_pkg::jsp_counts_t counts;    // Counts byte for the next capture

  assign counts.bytes_avail = tx_count;
  assign counts.space_free  = DEPTH - rx_count;
  assign cpu_rx_valid_o     = (rx_count != '0);

  ////////////////////////////////////////////////////////////////////////////
  // JTAG toward CPU
  ////////////////////////////////////////////////////////////////////////////

  jsp_wr_ctrl #(
    .SUPPORT_MULTI(SUPPORT_MULTI)
  ) wr_ctrl (
    .tck_i       (tck_i),
    .rst_i       (rst_i),
    .tap_i       (tap_i),
    .tdi_i       (tdi_i),
    .space_free_i(counts.space_free),
    .push_o      (rx_push),
    .data_o      (rx_data)
  );

  jsp_fifo rx_fifo (
    .tck_i  (tck_i),
    .rst_i  (rst_i),
    .push_i (rx_push),
    .data_i (rx_data),
    .pop_i  (cpu_rd_i),
    .data_o (cpu_rdata_o),
    .count_o(rx_count)
  );

  ////////////////////////////////////////////////////////////////////////////
  // CPU toward JTAG
  ////////////////////////////////////////////////////////////////////////////

  jsp_fifo tx_fifo (
    .tck_i  (tck_i),
    .rst_i  (rst_i),
    .push_i (cpu_wr_i),
    .data_i (cpu_wdata_i),
    .pop_i  (tx_pop),
    .data_o (tx_head),
    .count_o(tx_count)
  );

  jsp_rd_ctrl rd_ctrl (
    .tck_i   (tck_i),
    .rst_i   (rst_i),
    .tap_i   (tap_i),
    .counts_i(counts),
    .head_i  (tx_head),
    .pop_o   (tx_pop),
    .tdo_o   (tdo_o)
  );

endmodule

/* verif/jsp_assertions.sv */
/* Protocol checks bound into jsp_top
   The idle flag follows capture and update, so select is assumed high for whole scans */
`timescale 1ns/1ps
`include "jsp_consts.svh"

module jsp_assertions (
  input logic                tck_i,
  input logic                rst_i,
  input jsp_pkg::jsp_tap_t   tap_i,
  input logic                tdo_i,
  input logic                push_i,      // rx FIFO push from the input machine
  input logic                pop_i,       // tx FIFO pop from the output machine
  input jsp_pkg::jsp_count_t rx_count_i,
  input jsp_pkg::jsp_count_t tx_count_i
);

  localparam jsp_pkg::jsp_count_t DEPTH = `JSP_FIFO_DEPTH;

  int   fail_cnt = 0;  // Summed up by the testbench
  logic idle_q;        // Both machines idle

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) idle_q <= 1'b1;
    else if (tap_i.select && tap_i.capture) idle_q <= 1'b0;
    else if (tap_i.update) idle_q <= 1'b1;  // Scan over
  end

  ////////////////////////////////////////////////////////////////////////////

  strobe_single: assert property (@(posedge tck_i) disable iff (rst_i)
    (push_i |=> !push_i) and (pop_i |=> !pop_i))
    else begin
      $error("FIFO strobe longer than one cycle");
      fail_cnt++;
    end

  count_bound: assert property (@(posedge tck_i) disable iff (rst_i)
    (rx_count_i <= DEPTH) && (tx_count_i <= DEPTH))
    else begin
      $error("FIFO count above depth");
      fail_cnt++;
    end

  tdo_idle_low: assert property (@(posedge tck_i) disable iff (rst_i)
    idle_q |-> !tdo_i)
    else begin
      $error("TDO high while idle");
      fail_cnt++;
    end

endmodule

bind jsp_top jsp_assertions assertions_i (
  .tck_i     (tck_i),
  .rst_i     (rst_i),
  .tap_i     (tap_i),
  .tdo_i     (tdo_o),
  .push_i    (rx_push),
  .pop_i     (tx_pop),
  .rx_count_i(rx_count),
  .tx_count_i(tx_count)
);

/* verif/jsp_tb.sv */
/* Testbench for the JTAG serial port, DUT built with SUPPORT_MULTI set to 1
   Every scan starts with a start bit and a count byte, CPU traffic only runs between scans */
`timescale 1ns/1ps
`include "jsp_consts.svh"

module jsp_tb;

  localparam int MAX_BITS     = 128;     // Longest scan vector
  localparam int SCAN_MAX     = 8 * 12;  // Counts byte, start bit and ten data bytes, rounded up
  localparam int RAND_SCANS   = 12;
  localparam int WATCH_CYCLES = (5 + RAND_SCANS) * SCAN_MAX * 3 + 4000;  // Pauses can triple a scan

  logic               tck_i;
  logic               rst_i;
  jsp_pkg::jsp_tap_t  tap_i;
  logic               tdi_i;
  logic               tdo_o;
  logic               cpu_wr_i;
  jsp_pkg::jsp_byte_t cpu_wdata_i;
  logic               cpu_rd_i;
  jsp_pkg::jsp_byte_t cpu_rdata_o;
  logic               cpu_rx_valid_o;

  jsp_pkg::jsp_byte_t tx_model[$];  // CPU writes not yet seen on TDO
  jsp_pkg::jsp_byte_t rx_model[$];  // Bytes owed to the CPU
  jsp_pkg::jsp_byte_t send_q[$];    // Data bytes for the next scan
  logic [7:0]         exp_q[$];     // Pending compares
  logic [7:0]         act_q[$];
  string              sig_q[$];

  integer seed = 32'heff8_f46e;
  int     chk_cnt = 0;
  int     err_cnt = 0;
  int     test_cnt = 0;
  int     test_err = 0;  // Error count when the current test began

  jsp_top #(
    .SUPPORT_MULTI(1)
  ) jsp_top_i (
    .tck_i         (tck_i),
    .rst_i         (rst_i),
    .tap_i         (tap_i),
    .tdi_i         (tdi_i),
    .tdo_o         (tdo_o),
    .cpu_wr_i      (cpu_wr_i),
    .cpu_wdata_i   (cpu_wdata_i),
    .cpu_rd_i      (cpu_rd_i),
    .cpu_rdata_o   (cpu_rdata_o),
    .cpu_rx_valid_o(cpu_rx_valid_o)
  );

  initial begin
    tck_i = 1'b0;
    forever #50 tck_i = ~tck_i;  // 100 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and checking
  ////////////////////////////////////////////////////////////////////////////

  // Counts byte as the host sees it, bytes_avail high, space_free low
  function automatic logic [7:0] expected_counts(input int tx_size, input int rx_size);
    logic [3:0] avail;
    logic [3:0] space;
    avail = tx_size[3:0];
    space = 4'(`JSP_FIFO_DEPTH - rx_size);
    return {avail, space};
  endfunction

  task automatic check_value(input string sig, input logic [7:0] exp, input logic [7:0] act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("[FAIL] time %0t %s expected 0x%02h got 0x%02h", $time, sig, exp, act);
    end
  endtask

  task automatic queue_check(input string sig, input logic [7:0] exp, input logic [7:0] act);
    sig_q.push_back(sig);
    exp_q.push_back(exp);
    act_q.push_back(act);
  endtask

  // Compare process, stimulus queues on falling edges so nothing races here
  always @(posedge tck_i) begin
    while (act_q.size() > 0) begin
      check_value(sig_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks, all start and end just after a falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic scan(input logic [MAX_BITS-1:0] bits_in, input int nbits, input bit pauses,
                      output logic [MAX_BITS-1:0] bits_out);
    int i;
    int gap;
    bits_out      = '0;
    tap_i         = '0;
    tap_i.select  = 1'b1;
    tap_i.capture = 1'b1;
    @(negedge tck_i);
    tap_i.capture = 1'b0;
    for (i = 0; i < nbits; i++) begin
      if (pauses && (($random(seed) & 3) == 0)) gap = 1 + ($random(seed) & 1);
      else gap = 0;
      tap_i.shift = 1'b0;
      repeat (gap) @(negedge tck_i);  // Pause, all state holds
      tap_i.shift = 1'b1;
      tdi_i       = bits_in[i];
      bits_out[i] = tdo_o;            // Stable since the last rising edge
      @(negedge tck_i);
    end
    tap_i.shift  = 1'b0;
    tap_i.update = 1'b1;
    @(negedge tck_i);
    tap_i = '0;
    tdi_i = 1'b0;
    @(negedge tck_i);
  endtask

  // Start bit, count byte with K, then send_q, while reading the tx side
  task automatic run_scan(input int k, input bit pauses);
    logic [MAX_BITS-1:0] tdi_vec;
    logic [MAX_BITS-1:0] tdo_vec;
    logic [7:0]          counts_exp;
    logic [7:0]          exp;
    int                  n_tx;
    int                  n_push;
    int                  nbytes;
    int                  m;
    counts_exp = expected_counts(tx_model.size(), rx_model.size());
    n_tx       = tx_model.size();
    n_push     = `JSP_FIFO_DEPTH - rx_model.size();  // Space snapshot at capture
    if (k < n_push) n_push = k;
    if (send_q.size() < n_push) n_push = send_q.size();
    nbytes  = (n_tx + 1 > k + 2) ? n_tx + 1 : k + 2;
    tdi_vec = '0;
    tdi_vec[0]   = 1'b1;                               // Start bit
    tdi_vec[8:1] = {4'(k), 4'($random(seed))};         // Low nibble unused
    for (m = 0; m < send_q.size(); m++) tdi_vec[9 + 8 * m +: 8] = send_q[m];
    scan(tdi_vec, nbytes * 8, pauses, tdo_vec);
    queue_check("tdo_o counts", counts_exp, tdo_vec[7:0]);
    for (m = 1; m < nbytes; m++) begin
      if (m <= n_tx) exp = tx_model.pop_front();
      else exp = 8'h00;                                // Past the captured count
      queue_check($sformatf("tdo_o byte %0d", m), exp, tdo_vec[8 * m +: 8]);
    end
    for (m = 0; m < n_push; m++) rx_model.push_back(send_q[m]);
  endtask

  task automatic cpu_write(input jsp_pkg::jsp_byte_t b);
    cpu_wr_i    = 1'b1;
    cpu_wdata_i = b;
    if (tx_model.size() < `JSP_FIFO_DEPTH) tx_model.push_back(b);  // Full FIFO drops it
    @(negedge tck_i);
    cpu_wr_i = 1'b0;
  endtask

  task automatic cpu_read();
    jsp_pkg::jsp_byte_t exp;
    if (rx_model.size() == 0) begin
      queue_check("cpu_rx_valid_o", 8'h00, {7'b0, cpu_rx_valid_o});
    end else begin
      exp = rx_model.pop_front();
      queue_check("cpu_rx_valid_o", 8'h01, {7'b0, cpu_rx_valid_o});
      queue_check("cpu_rdata_o", exp, cpu_rdata_o);
    end
    cpu_rd_i = 1'b1;
    @(negedge tck_i);
    cpu_rd_i = 1'b0;
  endtask

  task automatic end_test(input string name);
    @(posedge tck_i);  // Compare process drains here
    @(negedge tck_i);
    test_cnt++;
    $display("[TEST] %0d %s: %0d errors", test_cnt, name, err_cnt - test_err);
    test_err = err_cnt;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int i;
    int n;
    int k;
    rst_i       = 1'b1;
    tap_i       = '0;
    tdi_i       = 1'b0;
    cpu_wr_i    = 1'b0;
    cpu_wdata_i = '0;
    cpu_rd_i    = 1'b0;
    repeat (5) @(negedge tck_i);
    rst_i = 1'b0;
    @(negedge tck_i);

    queue_check("cpu_rx_valid_o", 8'h00, {7'b0, cpu_rx_valid_o});
    run_scan(0, 1'b0);
    end_test("reset_and_empty_scan");

    for (i = 0; i < 5; i++) cpu_write(8'(49 + i * 17));
    run_scan(0, 1'b0);  // Counts 0x58 and five bytes
    run_scan(0, 1'b0);  // Nothing left
    end_test("cpu_to_jtag");

    send_q = '{8'h4a, 8'hc3, 8'h7e};
    run_scan(3, 1'b0);
    repeat (4) cpu_read();  // Last read sees valid low
    end_test("jtag_to_cpu");

    send_q.delete();
    for (i = 0; i < 10; i++) send_q.push_back(8'(8'h90 + i));
    run_scan(10, 1'b0);  // Space of 8 limits the pushes
    repeat (9) cpu_read();
    end_test("space_limit");

    for (n = 0; n < RAND_SCANS; n++) begin
      repeat ((($random(seed) & 15) % 10)) cpu_write(8'($random(seed)));
      send_q.delete();
      k = ($random(seed) & 15) % 11;
      for (i = 0; i < k; i++) send_q.push_back(8'($random(seed)));
      run_scan(k, 1'b1);
      repeat ((($random(seed) & 15) % 10)) cpu_read();
    end
    while (rx_model.size() > 0) cpu_read();
    cpu_read();
    end_test("random_both_ways");

    $display("Tests %0d, checks %0d, errors %0d, assertion failures %0d",
             test_cnt, chk_cnt, err_cnt, jsp_top_i.assertions_i.fail_cnt);
    if (err_cnt == 0 && jsp_top_i.assertions_i.fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCH_CYCLES * 100);
    $display("Timeout: the tests did not finish within %0d cycles", WATCH_CYCLES);
    $display("Some tests failed");
    $finish;
  end

endmodule

/* all.f */
+incdir+common
common/jsp_pkg.sv
design/jsp_fifo.sv
design/jsp_wr_ctrl.sv
design/jsp_rd_ctrl.sv
design/jsp_top.sv
verif/jsp_assertions.sv
verif/jsp_tb.sv

/* Makefile */
# Verilator build and run for the JTAG serial port testbench

SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = jsp_tb
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Some tests failed
PASS_MSG = All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# A stopped run leaves no pass line, so both searches are needed
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported errors"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
